/* src/cfar_pkg.sv */
`default_nettype none

package cfar_pkg;

  localparam int AMP_W      = 16;
  localparam int CHAN_W     = 5;   // up to 32 channels
  localparam int BIN_W      = 11;  // up to 2048 bins
  localparam int DPL_ADDR_W = 16;
  localparam int NUM_ZONES  = 6;

  typedef struct packed {
    logic [AMP_W-1:0] amp;
    logic [AMP_W-1:0] rng_gate;
    logic [AMP_W-1:0] rng_floor;
  } sample_t;

  typedef struct packed {
    logic        peak;
    logic [14:0] floor;
  } dpl_word_t;

  typedef struct packed {
    logic [15:0]       dpl_snr;  // high word
    logic [15:0]       rng_snr;
    logic [15:0]       amp;      // low word
    logic [CHAN_W-1:0] channel;
    logic [BIN_W-1:0]  bin;
  } target_rec_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_LO,
    RD_HI
  } rd_state_e;

  // range zones, first bin of each
  localparam logic [15:0] ZONE_START [NUM_ZONES] = '{
    16'd0, 16'd10, 16'd70, 16'd135, 16'd300, 16'd430
  };

  localparam logic [15:0] DPL_OFFSET [NUM_ZONES] = '{
    16'd1615, 16'd1275, 16'd1020, 16'd935, 16'd8500, 16'd8500
  };

endpackage

`default_nettype wire

/* src/frame_tracker.sv */
`default_nettype none

module frame_tracker #(
  parameter int NUM_CHANNELS = 32,
  parameter int NUM_BINS     = 2048
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            sample_valid_i,
  input  cfar_pkg::sample_t               sample_i,
  output logic                            trk_valid_o,
  output cfar_pkg::sample_t               trk_sample_o,
  output logic [cfar_pkg::CHAN_W-1:0]     trk_chan_o,
  output logic [cfar_pkg::BIN_W-1:0]      trk_bin_o,
  output logic                            burst_end_o,
  output logic                            frame_end_o,
  output logic                            dpl_rden_o,
  output logic [cfar_pkg::DPL_ADDR_W-1:0] dpl_addr_o
);
  import cfar_pkg::*;

  localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(NUM_CHANNELS - 1);

  logic              valid_q;
  logic [BIN_W:0]    bin_cnt;   // extra bit catches an overlong burst
  logic [CHAN_W-1:0] chan_cnt;

  assign burst_end_o = valid_q & ~sample_valid_i;  // falling edge

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q     <= 1'b0;
      bin_cnt     <= '0;
      chan_cnt    <= '0;
      trk_valid_o <= 1'b0;
      dpl_rden_o  <= 1'b0;
      frame_end_o <= 1'b0;
    end
    else
    begin
      valid_q     <= sample_valid_i;
      trk_valid_o <= sample_valid_i;
      dpl_rden_o  <= sample_valid_i;
      frame_end_o <= burst_end_o && (chan_cnt == LAST_CHAN);
      if (sample_valid_i)
        bin_cnt <= bin_cnt + 1'b1;
      else
        bin_cnt <= '0;
      if (burst_end_o)
        chan_cnt <= (chan_cnt == LAST_CHAN) ? '0 : chan_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample_valid_i)
    begin
      trk_sample_o <= sample_i;
      trk_chan_o   <= chan_cnt;
      trk_bin_o    <= bin_cnt[BIN_W-1:0];
      dpl_addr_o   <= DPL_ADDR_W'(bin_cnt * NUM_CHANNELS + chan_cnt);  // bin-major layout
    end
  end

  a_burst_len: assert property (@(posedge clk) disable iff (rst)
    sample_valid_i |-> bin_cnt < NUM_BINS);

endmodule

`default_nettype wire

/* src/range_peak_detect.sv */
`default_nettype none

module range_peak_detect (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        trk_valid_i,
  input  cfar_pkg::sample_t           trk_sample_i,
  input  logic [cfar_pkg::CHAN_W-1:0] trk_chan_i,
  input  logic [cfar_pkg::BIN_W-1:0]  trk_bin_i,
  output logic                        ctr_valid_o,
  output cfar_pkg::sample_t           ctr_sample_o,
  output logic [cfar_pkg::CHAN_W-1:0] ctr_chan_o,
  output logic [cfar_pkg::BIN_W-1:0]  ctr_bin_o,
  output logic                        ctr_peak_o
);
  import cfar_pkg::*;

  logic              w0_valid;   // center
  sample_t           w0_sample;
  logic [CHAN_W-1:0] w0_chan;
  logic [BIN_W-1:0]  w0_bin;
  logic              w1_valid;   // previous bin
  logic [AMP_W-1:0]  w1_amp;
  logic              peak_w;

  // gaps between bursts keep neighbors within one burst
  assign peak_w = w0_valid && w1_valid && trk_valid_i
               && (w0_sample.amp > w1_amp)
               && (w0_sample.amp > trk_sample_i.amp);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      w0_valid    <= 1'b0;
      w1_valid    <= 1'b0;
      ctr_valid_o <= 1'b0;
      ctr_peak_o  <= 1'b0;
    end
    else
    begin
      w0_valid    <= trk_valid_i;
      w1_valid    <= w0_valid;
      ctr_valid_o <= w0_valid;
      ctr_peak_o  <= peak_w;
    end
  end

  always_ff @(posedge clk)
  begin
    w0_sample    <= trk_sample_i;
    w0_chan      <= trk_chan_i;
    w0_bin       <= trk_bin_i;
    w1_amp       <= w0_sample.amp;
    ctr_sample_o <= w0_sample;  // lines up with the Doppler word
    ctr_chan_o   <= w0_chan;
    ctr_bin_o    <= w0_bin;
  end

endmodule

`default_nettype wire

/* src/target_decide.sv */
`default_nettype none

module target_decide #(
  parameter int NUM_CHANNELS = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        ctr_valid_i,
  input  cfar_pkg::sample_t           ctr_sample_i,
  input  logic [cfar_pkg::CHAN_W-1:0] ctr_chan_i,
  input  logic [cfar_pkg::BIN_W-1:0]  ctr_bin_i,
  input  logic                        ctr_peak_i,
  input  cfar_pkg::dpl_word_t         dpl_data_i,
  input  logic                        frame_end_i,
  input  logic                        fifo_full_i,
  output logic                        rec_wr_o,
  output cfar_pkg::target_rec_t       rec_o,
  output logic                        frame_done_o,
  output logic [15:0]                 frame_count_o
);
  import cfar_pkg::*;

  localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(NUM_CHANNELS - 1);

  dpl_word_t        dpl_q;
  logic [AMP_W-1:0] zone_ofs;
  logic [AMP_W:0]   dpl_gate;  // 17 bits, no wrap
  logic             chan_ok;
  logic             target_w;
  logic [2:0]       end_q;
  logic [15:0]      count_q;

  always_comb
  begin
    zone_ofs = DPL_OFFSET[0];
    for (int i = 1; i < NUM_ZONES; i++)
    begin
      if (ctr_bin_i >= ZONE_START[i])
        zone_ofs = DPL_OFFSET[i];
    end
  end

  assign dpl_gate = {2'b00, dpl_q.floor} + {1'b0, zone_ofs};
  assign chan_ok  = (ctr_chan_i != '0) && (ctr_chan_i != LAST_CHAN);  // edge rows excluded

  assign target_w = ctr_valid_i && ctr_peak_i && dpl_q.peak && chan_ok
                 && (ctr_sample_i.amp > ctr_sample_i.rng_gate)
                 && ({1'b0, ctr_sample_i.amp} > dpl_gate);

  // done lands one cycle after the last write can occur
  assign frame_done_o  = end_q[2];
  assign frame_count_o = count_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rec_wr_o <= 1'b0;
      end_q    <= '0;
      count_q  <= '0;
    end
    else
    begin
      rec_wr_o <= target_w && !fifo_full_i;  // dropped when full
      end_q    <= {end_q[1:0], frame_end_i};
      if (frame_done_o)
        count_q <= '0;
      else if (rec_wr_o)
        count_q <= count_q + 16'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    dpl_q <= dpl_data_i;
    if (target_w)
    begin
      rec_o.dpl_snr <= ctr_sample_i.amp - {1'b0, dpl_q.floor};
      rec_o.rng_snr <= ctr_sample_i.amp - ctr_sample_i.rng_floor;
      rec_o.amp     <= ctr_sample_i.amp;
      rec_o.channel <= ctr_chan_i;
      rec_o.bin     <= ctr_bin_i;
    end
  end

endmodule

`default_nettype wire

/* src/record_fifo.sv */
`default_nettype none

module record_fifo #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_i,
  input  cfar_pkg::target_rec_t wr_data_i,
  input  logic                  rd_i,
  output cfar_pkg::target_rec_t rd_data_o,
  output logic                  full_o,
  output logic                  empty_o
);
  import cfar_pkg::*;

  localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [ADDR_W-1:0] LAST_PTR = ADDR_W'(FIFO_DEPTH - 1);

  target_rec_t       mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   level;

  assign full_o  = (level == FIFO_DEPTH);
  assign empty_o = (level == '0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (wr_i)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (rd_i)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      if (wr_i && !rd_i)
        level <= level + 1'b1;
      else if (rd_i && !wr_i)
        level <= level - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_i)
      mem[wr_ptr] <= wr_data_i;
    if (rd_i)
      rd_data_o <= mem[rd_ptr];  // valid the cycle after rd
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_i |-> !empty_o);

endmodule

`default_nettype wire

/* src/target_readout.sv */
`default_nettype none

module target_readout (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  frame_done_i,
  input  logic [15:0]           frame_count_i,
  input  logic                  empty_i,
  input  cfar_pkg::target_rec_t rd_data_i,
  output logic                  rd_o,
  output logic                  out_tvalid_o,
  output logic [31:0]           out_tdata_o,
  output logic                  out_tlast_o,
  output logic [15:0]           out_tnum_o,
  output logic [15:0]           out_count_o
);
  import cfar_pkg::*;

  rd_state_e   state_q;
  logic [15:0] left_q;   // records not yet finished
  logic        start_w;
  logic        more_w;

  assign start_w = (state_q == RD_IDLE) && frame_done_i
                && (frame_count_i != 16'd0) && !empty_i;
  assign more_w  = (state_q == RD_HI) && (left_q != 16'd1);

  // next record is popped while the high word goes out
  assign rd_o = start_w || (more_w && !empty_i);

  assign out_tvalid_o = (state_q != RD_IDLE);
  assign out_tdata_o  = (state_q == RD_HI) ? rd_data_i[63:32] : rd_data_i[31:0];
  assign out_tlast_o  = (state_q == RD_HI) && (left_q == 16'd1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= RD_IDLE;
      left_q      <= '0;
      out_tnum_o  <= '0;
      out_count_o <= '0;
    end
    else
    begin
      case (state_q)
        RD_IDLE:
        begin
          if (start_w)
          begin
            state_q     <= RD_LO;
            left_q      <= frame_count_i;
            out_tnum_o  <= {frame_count_i[14:0], 1'b0};  // two words each
            out_count_o <= frame_count_i;
          end
        end
        RD_LO:
          state_q <= RD_HI;
        RD_HI:
        begin
          if (out_tlast_o)
          begin
            state_q     <= RD_IDLE;
            out_tnum_o  <= '0;
            out_count_o <= '0;
          end
          else
          begin
            state_q <= RD_LO;
            left_q  <= left_q - 16'd1;
          end
        end
        default:
          state_q <= RD_IDLE;
      endcase
    end
  end

  a_tlast_valid: assert property (@(posedge clk) disable iff (rst)
    out_tlast_o |-> out_tvalid_o);

  // the decision stage counts only records that reached the FIFO
  a_count_matches_fifo: assert property (@(posedge clk) disable iff (rst)
    (frame_done_i && frame_count_i != 16'd0) |-> !empty_i);

endmodule

`default_nettype wire

/* src/cfar_target_top.sv */
`default_nettype none

module cfar_target_top #(
  parameter int NUM_CHANNELS = 32,
  parameter int NUM_BINS     = 2048,
  parameter int FIFO_DEPTH   = 64
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              sample_valid_i,
  input  cfar_pkg::sample_t                 sample_i,
  input  cfar_pkg::dpl_word_t               dpl_data_i,
  output logic                              dpl_rden_o,
  output logic [cfar_pkg::DPL_ADDR_W-1:0]   dpl_addr_o,
  output logic                              out_tvalid_o,
  output logic [31:0]                       out_tdata_o,
  output logic                              out_tlast_o,
  output logic [15:0]                       out_tnum_o,
  output logic [15:0]                       out_count_o
);
  import cfar_pkg::*;

  logic              trk_valid;
  sample_t           trk_sample;
  logic [CHAN_W-1:0] trk_chan;
  logic [BIN_W-1:0]  trk_bin;
  logic              frame_end;
  logic              ctr_valid;
  sample_t           ctr_sample;
  logic [CHAN_W-1:0] ctr_chan;
  logic [BIN_W-1:0]  ctr_bin;
  logic              ctr_peak;
  logic              rec_wr;
  target_rec_t       rec;
  logic              frame_done;
  logic [15:0]       frame_count;
  logic              rec_rd;
  target_rec_t       rec_rd_data;
  logic              fifo_full;
  logic              fifo_empty;

  frame_tracker #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .NUM_BINS     (NUM_BINS)
  ) u_frame_tracker (
    .clk            (clk),
    .rst            (rst),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .trk_valid_o    (trk_valid),
    .trk_sample_o   (trk_sample),
    .trk_chan_o     (trk_chan),
    .trk_bin_o      (trk_bin),
    .burst_end_o    (),           // used inside for channel count
    .frame_end_o    (frame_end),
    .dpl_rden_o     (dpl_rden_o),
    .dpl_addr_o     (dpl_addr_o)
  );

  range_peak_detect u_range_peak_detect (
    .clk          (clk),
    .rst          (rst),
    .trk_valid_i  (trk_valid),
    .trk_sample_i (trk_sample),
    .trk_chan_i   (trk_chan),
    .trk_bin_i    (trk_bin),
    .ctr_valid_o  (ctr_valid),
    .ctr_sample_o (ctr_sample),
    .ctr_chan_o   (ctr_chan),
    .ctr_bin_o    (ctr_bin),
    .ctr_peak_o   (ctr_peak)
  );

  target_decide #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_target_decide (
    .clk           (clk),
    .rst           (rst),
    .ctr_valid_i   (ctr_valid),
    .ctr_sample_i  (ctr_sample),
    .ctr_chan_i    (ctr_chan),
    .ctr_bin_i     (ctr_bin),
    .ctr_peak_i    (ctr_peak),
    .dpl_data_i    (dpl_data_i),
    .frame_end_i   (frame_end),
    .fifo_full_i   (fifo_full),
    .rec_wr_o      (rec_wr),
    .rec_o         (rec),
    .frame_done_o  (frame_done),
    .frame_count_o (frame_count)
  );

  record_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_record_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_i      (rec_wr),
    .wr_data_i (rec),
    .rd_i      (rec_rd),
    .rd_data_o (rec_rd_data),
    .full_o    (fifo_full),
    .empty_o   (fifo_empty)
  );

  target_readout u_target_readout (
    .clk           (clk),
    .rst           (rst),
    .frame_done_i  (frame_done),
    .frame_count_i (frame_count),
    .empty_i       (fifo_empty),
    .rd_data_i     (rec_rd_data),
    .rd_o          (rec_rd),
    .out_tvalid_o  (out_tvalid_o),
    .out_tdata_o   (out_tdata_o),
    .out_tlast_o   (out_tlast_o),
    .out_tnum_o    (out_tnum_o),
    .out_count_o   (out_count_o)
  );

endmodule

`default_nettype wire

/* tests/doppler_ram_model.sv */
`default_nettype none

module doppler_ram_model #(
  parameter int DEPTH = 64
) (
  input  logic                            clk,
  input  logic                            rden_i,
  input  logic [cfar_pkg::DPL_ADDR_W-1:0] addr_i,
  output cfar_pkg::dpl_word_t             data_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import cfar_pkg::*;

  dpl_word_t mem [DEPTH];  // filled by the testbench before each frame

  always_ff @(posedge clk)
  begin
    if (rden_i)
      data_o <= mem[addr_i];  // one cycle read latency
  end

endmodule

`default_nettype wire

/* tests/tb_cfar_target.sv */
`default_nettype none

module tb_cfar_target;
  timeunit 1ns;
  timeprecision 1ps;
  import cfar_pkg::*;

  localparam int NUM_CHANNELS = 4;
  localparam int NUM_BINS     = 16;
  localparam int FIFO_DEPTH   = 8;
  localparam int CLK_PERIOD   = 8;
  localparam int GAP          = 4;   // idle cycles between bursts
  localparam int READOUT_WAIT = 30;  // idle cycles allowed before the first word
  localparam int NUM_FRAMES   = 8;
  localparam int FRAME_CYCLES = NUM_CHANNELS * (NUM_BINS + GAP) + READOUT_WAIT
                              + 2 * FIFO_DEPTH + 8;
  localparam int RUN_CYCLES   = NUM_FRAMES * FRAME_CYCLES + 200;

  logic                  clk;
  logic                  rst;
  logic                  sample_valid_i;
  sample_t               sample_i;
  dpl_word_t             dpl_data;
  logic                  dpl_rden;
  logic [DPL_ADDR_W-1:0] dpl_addr;
  logic                  out_tvalid_o;
  logic [31:0]           out_tdata_o;
  logic                  out_tlast_o;
  logic [15:0]           out_tnum_o;
  logic [15:0]           out_count_o;

  logic [15:0] amp_a   [NUM_CHANNELS][NUM_BINS];
  logic [15:0] gate_a  [NUM_CHANNELS][NUM_BINS];
  logic [15:0] floor_a [NUM_CHANNELS][NUM_BINS];
  dpl_word_t   dpl_a   [NUM_CHANNELS * NUM_BINS];
  target_rec_t exp_q[$];
  logic [31:0] words[$];
  logic [31:0] lcg_state;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_err0;

  cfar_target_top #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .NUM_BINS     (NUM_BINS),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) u_dut (
    .clk            (clk),
    .rst            (rst),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .dpl_data_i     (dpl_data),
    .dpl_rden_o     (dpl_rden),
    .dpl_addr_o     (dpl_addr),
    .out_tvalid_o   (out_tvalid_o),
    .out_tdata_o    (out_tdata_o),
    .out_tlast_o    (out_tlast_o),
    .out_tnum_o     (out_tnum_o),
    .out_count_o    (out_count_o)
  );

  doppler_ram_model #(
    .DEPTH (NUM_CHANNELS * NUM_BINS)
  ) u_ram (
    .clk    (clk),
    .rden_i (dpl_rden),
    .addr_i (dpl_addr),
    .data_o (dpl_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];  // upper bits are the better ones
  endfunction

  // doppler SNR offset by range zone
  function automatic int zone_offset(input int bin);
    if (bin >= 430)
      return 8500;
    else if (bin >= 300)
      return 8500;
    else if (bin >= 135)
      return 935;
    else if (bin >= 70)
      return 1020;
    else if (bin >= 10)
      return 1275;
    return 1615;
  endfunction

  task automatic check_rec(input target_rec_t got, input target_rec_t exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s: got ch %0d bin %0d amp %0d rng %0d dpl %0d",
               $time, what, got.channel, got.bin, got.amp, got.rng_snr, got.dpl_snr);
      $display("   expected ch %0d bin %0d amp %0d rng %0d dpl %0d",
               exp.channel, exp.bin, exp.amp, exp.rng_snr, exp.dpl_snr);
    end
  endtask

  task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s: got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic start_test();
    test_err0 = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err0)
      $display("%s: ok", name);
    else
    begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - test_err0);
    end
  endtask

  // flat background, no peaks, no doppler flags
  task automatic clear_frame();
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      for (int b = 0; b < NUM_BINS; b++)
      begin
        amp_a[c][b]   = 16'd100;
        gate_a[c][b]  = 16'd50;
        floor_a[c][b] = 16'd20;
        dpl_a[b * NUM_CHANNELS + c] = '0;
      end
    end
  endtask

  task automatic set_peak(input int c, input int b, input int amp, input int dfloor,
                          input bit dpeak);
    amp_a[c][b] = 16'(amp);
    dpl_a[b * NUM_CHANNELS + c] = '{peak: dpeak, floor: 15'(dfloor)};
  endtask

  task automatic load_ram();
    for (int a = 0; a < NUM_CHANNELS * NUM_BINS; a++)
      u_ram.mem[a] = dpl_a[a];
  endtask

  // reference model, channel then bin order, stops at FIFO depth
  task automatic build_expected();
    logic [15:0] a;
    dpl_word_t   d;
    bit          is_peak;
    target_rec_t r;
    exp_q.delete();
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      for (int b = 1; b < NUM_BINS - 1; b++)
      begin
        a = amp_a[c][b];
        d = dpl_a[b * NUM_CHANNELS + c];
        is_peak = (a > amp_a[c][b - 1]) && (a > amp_a[c][b + 1]);
        if (is_peak && (a > gate_a[c][b]) && d.peak
            && (int'(a) > int'(d.floor) + zone_offset(b))
            && (c != 0) && (c != NUM_CHANNELS - 1) && (exp_q.size() < FIFO_DEPTH))
        begin
          r.dpl_snr = a - {1'b0, d.floor};
          r.rng_snr = a - floor_a[c][b];
          r.amp     = a;
          r.channel = CHAN_W'(c);
          r.bin     = BIN_W'(b);
          exp_q.push_back(r);
        end
      end
    end
  endtask

  task automatic drive_burst(input int c);
    sample_t s;
    for (int b = 0; b < NUM_BINS; b++)
    begin
      s.amp       = amp_a[c][b];
      s.rng_gate  = gate_a[c][b];
      s.rng_floor = floor_a[c][b];
      @(posedge clk);
      sample_valid_i <= 1'b1;
      sample_i       <= s;
    end
    @(posedge clk);
    sample_valid_i <= 1'b0;
    repeat (GAP - 1) @(posedge clk);
  endtask

  task automatic collect_words(input string name);
    int idle;
    bit done;
    idle = 0;
    done = 0;
    words.delete();
    while (!done)
    begin
      @(negedge clk);
      if (out_tvalid_o)
      begin
        check_count(out_tnum_o, 16'(2 * exp_q.size()), {name, " out_tnum_o"});
        check_count(out_count_o, 16'(exp_q.size()), {name, " out_count_o"});
        words.push_back(out_tdata_o);
        if (out_tlast_o)
          done = 1;
      end
      else if (words.size() != 0)
      begin
        errors++;
        $display("%s: output stream stopped after %0d words with no last word",
                 name, words.size());
        done = 1;
      end
      else
      begin
        idle++;
        if (idle == READOUT_WAIT)
          done = 1;
      end
    end
    repeat (4)
    begin
      @(negedge clk);
      if (out_tvalid_o)
      begin
        errors++;
        $display("%s: extra word 0x%08h after the end of the stream", name, out_tdata_o);
      end
      check_count(out_tnum_o, 16'd0, {name, " out_tnum_o after last"});
      check_count(out_count_o, 16'd0, {name, " out_count_o after last"});
    end
  endtask

  task automatic run_frame(input string name, input int n_expect);
    target_rec_t got;
    load_ram();
    build_expected();
    if (n_expect >= 0)
      check_count(16'(exp_q.size()), 16'(n_expect), {name, " model record count"});
    for (int c = 0; c < NUM_CHANNELS; c++)
      drive_burst(c);
    collect_words(name);
    if (words.size() < 2 * exp_q.size())
    begin
      errors++;
      $display("%s: %0d output words missing", name, 2 * exp_q.size() - words.size());
    end
    else if (words.size() > 2 * exp_q.size())
    begin
      errors++;
      $display("%s: %0d extra output words", name, words.size() - 2 * exp_q.size());
    end
    for (int i = 0; i < exp_q.size() && 2 * i + 1 < words.size(); i++)
    begin
      got = {words[2 * i + 1], words[2 * i]};  // low word first
      check_rec(got, exp_q[i], $sformatf("%s record %0d", name, i));
    end
  endtask

  task automatic reset_state();
    start_test();
    check_count({15'd0, dpl_rden}, 16'd0, "dpl_rden_o after reset");
    check_count({15'd0, out_tvalid_o}, 16'd0, "out_tvalid_o after reset");
    check_count({15'd0, out_tlast_o}, 16'd0, "out_tlast_o after reset");
    check_count(out_tnum_o, 16'd0, "out_tnum_o after reset");
    check_count(out_count_o, 16'd0, "out_count_o after reset");
    end_test("reset state");
  endtask

  task automatic single_target();
    start_test();
    clear_frame();
    set_peak(1, 5, 3000, 1000, 1'b1);
    floor_a[1][5] = 16'd500;
    run_frame("single target", 1);
    end_test("single target");
  endtask

  task automatic one_fault_peaks();
    start_test();
    clear_frame();
    set_peak(1, 4, 3000, 0, 1'b1);
    gate_a[1][4] = 16'd3000;            // at the range gate
    set_peak(1, 9, 3000, 1385, 1'b1);   // at floor plus offset
    set_peak(2, 4, 3000, 0, 1'b0);      // flag clear
    set_peak(2, 9, 3000, 0, 1'b1);
    set_peak(2, 10, 3000, 0, 1'b1);     // equal neighbor
    run_frame("one fault peaks", 0);
    end_test("one fault peaks");
  endtask

  task automatic edge_peaks();
    start_test();
    clear_frame();
    set_peak(0, 5, 3000, 0, 1'b1);
    set_peak(NUM_CHANNELS - 1, 5, 3000, 0, 1'b1);
    set_peak(1, 0, 3000, 0, 1'b1);
    set_peak(2, NUM_BINS - 1, 3000, 0, 1'b1);
    run_frame("edge peaks", 0);
    end_test("edge peaks");
  endtask

  task automatic zone_boundary();
    start_test();
    clear_frame();
    set_peak(1, 9, 1000 + 1615 + 1, 1000, 1'b1);
    set_peak(2, 9, 1000 + 1615, 1000, 1'b1);
    run_frame("zone bin 9", 1);
    clear_frame();
    set_peak(1, 10, 1000 + 1275 + 1, 1000, 1'b1);
    set_peak(2, 10, 1000 + 1275, 1000, 1'b1);
    run_frame("zone bin 10", 1);
    end_test("zone boundary");
  endtask

  task automatic random_frame();
    start_test();
    lcg_state = 32'd34;
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      for (int b = 0; b < NUM_BINS; b++)
      begin
        amp_a[c][b]   = lcg_next() & 16'h0fff;
        gate_a[c][b]  = lcg_next() & 16'h07ff;
        floor_a[c][b] = lcg_next() & 16'h03ff;
        dpl_a[b * NUM_CHANNELS + c] = '{peak: lcg_next() & 16'h0001 ? 1'b1 : 1'b0,
                                        floor: 15'(lcg_next() & 16'h03ff)};
      end
    end
    run_frame("random frame", -1);
    end_test("random frame");
  endtask

  task automatic fifo_overflow();
    start_test();
    clear_frame();
    for (int c = 1; c <= 2; c++)
    begin
      for (int b = 2; b <= 12; b += 2)
        set_peak(c, b, 4000 + c * 100 + b, 0, 1'b1);
    end
    run_frame("twelve targets", FIFO_DEPTH);
    clear_frame();
    set_peak(1, 5, 3000, 1000, 1'b1);
    run_frame("frame after overflow", 1);
    end_test("fifo overflow");
  endtask

  initial
  begin
    rst            = 1'b1;
    sample_valid_i = 1'b0;
    sample_i       = '0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err0      = 0;
    lcg_state      = 32'd34;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    reset_state();
    single_target();
    one_fault_peaks();
    edge_peaks();
    zone_boundary();
    random_frame();
    fifo_overflow();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
src/cfar_pkg.sv
src/frame_tracker.sv
src/range_peak_detect.sv
src/target_decide.sv
src/record_fifo.sv
src/target_readout.sv
src/cfar_target_top.sv
tests/doppler_ram_model.sv
tests/tb_cfar_target.sv

/* Bender.yml */
package:
  name: cfar_target

sources:
  - src/cfar_pkg.sv
  - src/frame_tracker.sv
  - src/range_peak_detect.sv
  - src/target_decide.sv
  - src/record_fifo.sv
  - src/target_readout.sv
  - src/cfar_target_top.sv
  - target: test
    files:
      - tests/doppler_ram_model.sv
      - tests/tb_cfar_target.sv
